/* ifetch.f */
source/isa_pkg.sv
source/fetch_pkg.sv
source/fetch_pc.sv
source/fetch_bus.sv
source/fetch_buffers.sv
source/branch_back.sv
source/ifetch_top.sv
bench/imem_model.sv
bench/ifetch_tb.sv

/* run.sh */
#!/bin/sh
# builds the fetch front end testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module ifetch_tb \
	-f ifetch.f \
	--Mdir obj_dir \
	-o ifetch_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/ifetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test OK$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* bench/ifetch_tb.sv */
`timescale 1ns/1ps
// testbench for the fetch front end with a queue model and directed tests
module ifetch_tb
	import isa_pkg::*;
	import fetch_pkg::*;
();

	localparam int    HALF         = 50;
	localparam int    DRIVE_DLY    = 10;
	localparam int    RESET_CYCLES = 16;
	localparam addr_t LOOP_BRA_PC  = 32'h0000_003c;
	localparam int    LOOP_DISP    = -6;
	localparam addr_t MISS_PC      = 32'h0000_0400;

	// entry counts per test and the cycle budget built from them
	localparam int N_STREAM    = 64;
	localparam int N_LOOP      = 80;
	localparam int N_MISS_PRE  = 20;
	localparam int N_MISS_POST = 32;
	localparam int N_ENTRIES   = 3 * N_STREAM + N_LOOP + N_MISS_PRE + N_MISS_POST;
	localparam int CYCLE_LIMIT = 6 * (RESET_CYCLES + 4) + 12 * N_ENTRIES;

	logic        clk;
	logic        rst;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        free0;
	logic        free1;
	logic        branchmiss;
	addr_t       misspc;
	fb_entry_t   slot0;
	fb_entry_t   slot1;
	logic        loop_img;
	logic [2:0]  wait_cycles;
	pair_t       look_dat;

	logic        rand_free;
	logic        rand_wait;
	logic [31:0] rng;
	addr_t       exp_pc;
	int          n_taken;
	int          n_branches;
	int          test_errors;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          cycle_cnt = 0;

	ifetch_top #(.ADDR_W(ADDR_W)) u_ifetch_top (
		.clk        (clk),
		.rst        (rst),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.free0      (free0),
		.free1      (free1),
		.branchmiss (branchmiss),
		.misspc     (misspc),
		.slot0      (slot0),
		.slot1      (slot1)
	);

	imem_model #(.LOOP_BRA_PC(LOOP_BRA_PC), .LOOP_DISP(LOOP_DISP)) u_imem (
		.clk         (clk),
		.rst         (rst),
		.loop_img    (loop_img),
		.wait_cycles (wait_cycles),
		.req         (wb_req),
		.rsp         (wb_rsp),
		.look_adr    ({slot1.pc, slot0.pc}),
		.look_dat    (look_dat)
	);

	initial clk = 1'b0;
	always #(HALF) clk = ~clk;

	// hard stop in case the front end stops delivering entries
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles with tests still waiting", cycle_cnt);
			$display("Test FAILED");
			$finish;
		end
	end

	// ========================================
	// stimulus and queue model
	// ========================================

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic drive_inputs();
		rng = next_rand(rng);
		// free0 is high three times out of four under back-pressure
		free0       = rand_free ? (rng[0] | rng[1]) : 1'b1;
		free1       = rand_free ? rng[2] : 1'b1;
		wait_cycles = rand_wait ? 3'(rng[15:8] % 8'd6) : 3'd0;
	endtask

	task automatic expect_low(input string name, input logic got);
		assert (got == 1'b0) else begin
			$display("[ERROR] %s got %h expected 0", name, got);
			test_errors++;
		end
	endtask

	// one queue entry, checked against program order and memory contents
	task automatic check_entry(input string name, input fb_entry_t e, input instr_t word);
		addr_t offset;
		assert (e.pc == exp_pc) else begin
			$display("[ERROR] %s.pc got %h expected %h", name, e.pc, exp_pc);
			test_errors++;
		end
		assert (e.instr == word) else begin
			$display("[ERROR] %s.instr at pc %h got %h expected %h", name, e.pc, e.instr,
				word);
			test_errors++;
		end
		assert (!(loop_img && e.pc > LOOP_BRA_PC)) else begin
			$display("word at pc %h past the loop branch was enqueued", e.pc);
			test_errors++;
		end
		n_taken++;
		// a backward branch sends the stream to pc plus the scaled displacement
		if (word[OPCODE_W-1:0] == OP_BRA && word[INSTR_W-1]) begin
			offset = {{(ADDR_W-DISP_W-2){word[INSTR_W-1]}}, word[INSTR_W-1:DISP_LSB], 2'b00};
			exp_pc = e.pc + offset;
			n_branches++;
		end else begin
			exp_pc = e.pc + addr_t'(INSTR_BYTES);
		end
	endtask

	// outputs are sampled mid-cycle, where they and free0/free1 hold the
	// values the DUT will see at the next rising edge
	task automatic run_cycle();
		logic take0;
		logic take1;
		@(negedge clk);
		// the front end only reads, and stb always travels with cyc
		expect_low("wb_req.we", wb_req.we);
		assert (wb_req.stb == wb_req.cyc) else begin
			$display("[ERROR] wb_req.stb got %h expected %h", wb_req.stb, wb_req.cyc);
			test_errors++;
		end
		take0 = slot0.v && free0;
		take1 = slot1.v && free0 && (free1 || !slot0.v);
		if (take0) begin
			check_entry("slot0", slot0, look_dat[0]);
		end
		if (take1) begin
			check_entry("slot1", slot1, look_dat[1]);
		end
		@(posedge clk);
		#(DRIVE_DLY);
		drive_inputs();
	endtask

	task automatic run_entries(input int target);
		while (n_taken < target) begin
			run_cycle();
		end
	endtask

	// ========================================
	// test control
	// ========================================

	task automatic apply_reset();
		@(posedge clk);
		#(DRIVE_DLY);
		rst        = 1'b1;
		branchmiss = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DLY);
		rst = 1'b0;
	endtask

	task automatic prepare_test(input logic use_loop, input logic rnd_free, input logic rnd_wait);
		loop_img  = use_loop;
		rand_free = rnd_free;
		rand_wait = rnd_wait;
		apply_reset();
		exp_pc      = '0;
		n_taken     = 0;
		n_branches  = 0;
		test_errors = 0;
		drive_inputs();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("%s: %s with %0d errors", name, (test_errors == 0) ? "passed" : "failed",
			test_errors);
	endtask

	// ========================================
	// tests
	// ========================================

	// the bus and both slots stay quiet through reset and the cycle after it
	task automatic test_reset();
		test_errors = 0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#(DRIVE_DLY);
			if (i == RESET_CYCLES - 1) begin
				rst = 1'b0;
			end
			@(negedge clk);
			expect_low("wb_req.cyc", wb_req.cyc);
			expect_low("wb_req.stb", wb_req.stb);
			expect_low("slot0.v", slot0.v);
			expect_low("slot1.v", slot1.v);
		end
		finish_test("reset");
	endtask

	task automatic test_stream(input string name, input logic rnd_free, input logic rnd_wait);
		prepare_test(1'b0, rnd_free, rnd_wait);
		run_entries(N_STREAM);
		finish_test(name);
	endtask

	task automatic test_back_branch();
		prepare_test(1'b1, 1'b1, 1'b1);
		run_entries(N_LOOP);
		assert (n_branches >= 5) else begin
			$display("the loop branch was enqueued only %0d times", n_branches);
			test_errors++;
		end
		finish_test("backward branch");
	endtask

	// the pulse cycle takes nothing, so every older entry must disappear
	task automatic test_branch_miss();
		prepare_test(1'b0, 1'b0, 1'b1);
		run_entries(N_MISS_PRE);
		free0      = 1'b0;
		free1      = 1'b0;
		branchmiss = 1'b1;
		misspc     = MISS_PC;
		@(negedge clk);
		@(posedge clk);
		#(DRIVE_DLY);
		branchmiss = 1'b0;
		exp_pc     = MISS_PC;
		n_taken    = 0;
		drive_inputs();
		run_entries(N_MISS_POST);
		finish_test("branch miss");
	endtask

	initial begin
		rst          = 1'b1;
		branchmiss   = 1'b0;
		misspc       = '0;
		free0        = 1'b1;
		free1        = 1'b1;
		loop_img     = 1'b0;
		wait_cycles  = 3'd0;
		rand_free    = 1'b0;
		rand_wait    = 1'b0;
		rng          = 32'd70482;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;

		test_reset();
		test_stream("straight line", 1'b0, 1'b0);
		test_stream("back-pressure", 1'b1, 1'b0);
		test_stream("wait states", 1'b0, 1'b1);
		test_back_branch();
		test_branch_miss();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* bench/imem_model.sv */
`timescale 1ns/1ps
// instruction memory acting as a wishbone classic slave with two program images and wait states
module imem_model
	import isa_pkg::*;
	import fetch_pkg::*;
#(
	parameter addr_t LOOP_BRA_PC = 32'h0000_003c,
	parameter int    LOOP_DISP   = -6
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        loop_img,
	input  logic [2:0]  wait_cycles,
	input  wb_req_t     req,
	output wb_rsp_t     rsp,
	input  addr_t [1:0] look_adr,
	output pair_t       look_dat
);

	logic       active_q;
	logic       ack_q;
	logic [2:0] left_q;

	// ========================================
	// program images
	// ========================================

	// the straight image mixes every address bit into the word, and its low
	// two bits are 01 so it never decodes as a branch or as a nop
	// the loop image is the same apart from one backward branch
	function automatic instr_t image_word(input logic use_loop, input addr_t a);
		disp_t disp;
		disp = disp_t'(LOOP_DISP);
		if (use_loop && a == LOOP_BRA_PC) begin
			return {disp, {(DISP_LSB-OPCODE_W){1'b0}}, OP_BRA};
		end
		return {a[31:7] ^ a[24:0], a[6:2], 2'b01};
	endfunction

	// ========================================
	// bus slave
	// ========================================

	// the wait count is latched on the first cycle a request is seen,
	// then ack follows once it has run down
	always_ff @(posedge clk) begin
		if (rst) begin
			active_q <= 1'b0;
			ack_q    <= 1'b0;
			left_q   <= '0;
		end else if (ack_q) begin
			// the master drops cyc the cycle after ack
			ack_q    <= 1'b0;
			active_q <= 1'b0;
		end else if (req.cyc && req.stb) begin
			if (!active_q) begin
				active_q <= 1'b1;
				left_q   <= wait_cycles;
			end else if (left_q == 3'd0) begin
				ack_q <= 1'b1;
			end else begin
				left_q <= left_q - 3'd1;
			end
		end
	end

	// read data follows the held address, lower word first
	assign rsp.ack    = ack_q;
	assign rsp.dat[0] = image_word(loop_img, req.adr);
	assign rsp.dat[1] = image_word(loop_img, req.adr + addr_t'(INSTR_BYTES));

	// side port so the bench can see what memory holds at the slot addresses
	assign look_dat[0] = image_word(loop_img, look_adr[0]);
	assign look_dat[1] = image_word(loop_img, look_adr[1]);

endmodule

/* source/ifetch_top.sv */
`timescale 1ns/1ps
// dual issue instruction fetch front end with pc, bus master, fetch buffers and branch detect
module ifetch_top
	import fetch_pkg::*;
#(
	parameter int ADDR_W = fetch_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	output wb_req_t           wb_req,
	input  wb_rsp_t           wb_rsp,
	input  logic              free0,
	input  logic              free1,
	input  logic              branchmiss,
	input  logic [ADDR_W-1:0] misspc,
	output fb_entry_t         slot0,
	output fb_entry_t         slot1
);

	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pair_pc;
	logic              fetch_done;
	logic              fetch_want;
	pair_t             fetch_pair;
	redirect_t         bb_redirect;
	redirect_t         miss_redirect;
	redirect_t         redirect;
	logic [1:0]        kill_after;
	fb_entry_t         buf_slot1;

	// ========================================
	// redirect merge
	// ========================================

	// a branch miss comes from further down the pipe and overrides any
	// loop the front end has found on its own
	assign miss_redirect = '{v: branchmiss, target: misspc};
	assign redirect      = miss_redirect.v ? miss_redirect : bb_redirect;

	// slot1 behind a back branch in slot0 must not reach the queue
	assign slot1 = '{v: buf_slot1.v & ~kill_after[0], pc: buf_slot1.pc, instr: buf_slot1.instr};

	// ========================================
	// blocks
	// ========================================

	fetch_pc #(.ADDR_W(ADDR_W)) u_fetch_pc (
		.clk        (clk),
		.rst        (rst),
		.fetch_done (fetch_done),
		.redirect   (redirect),
		.pc         (pc)
	);

	fetch_bus #(.ADDR_W(ADDR_W)) u_fetch_bus (
		.clk           (clk),
		.rst           (rst),
		.pc            (pc),
		.fetch_want    (fetch_want),
		.redirect_seen (redirect.v),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp),
		.fetch_done    (fetch_done),
		.fetch_pair    (fetch_pair),
		.fetch_pc      (pair_pc)
	);

	fetch_buffers #(.ADDR_W(ADDR_W)) u_fetch_buffers (
		.clk        (clk),
		.rst        (rst),
		.fetch_done (fetch_done),
		.fetch_pair (fetch_pair),
		.fetch_pc   (pair_pc),
		.free0      (free0),
		.free1      (free1),
		.flush      (branchmiss),
		.kill_after (kill_after),
		.slot0      (slot0),
		.slot1      (buf_slot1),
		.fetch_want (fetch_want)
	);

	// looks at the raw leading pair so the slot1 mask does not feed back
	branch_back u_branch_back (
		.slot0      (slot0),
		.slot1      (buf_slot1),
		.redirect   (bb_redirect),
		.kill_after (kill_after)
	);

endmodule

/* source/branch_back.sv */
`timescale 1ns/1ps
// backward branch detector for the leading pair, gives the loop target and what to kill
module branch_back
	import isa_pkg::*;
	import fetch_pkg::*;
(
	input  fb_entry_t  slot0,
	input  fb_entry_t  slot1,
	output redirect_t  redirect,
	output logic [1:0] kill_after
);

	logic      bb0;
	logic      bb1;
	fb_entry_t br;
	disp_t     disp;
	addr_t     disp_ext;

	// ========================================
	// detection
	// ========================================

	always_comb begin
		// slot0 is older, so its branch decides when both slots hold one
		bb0 = slot0.v && is_back_branch(slot0.instr);
		bb1 = slot1.v && is_back_branch(slot1.instr) && !bb0;

		br = bb0 ? slot0 : slot1;

		// sign extend the instruction count before scaling it to bytes
		disp     = branch_disp(br.instr);
		disp_ext = {{(ADDR_W-DISP_W){disp[DISP_W-1]}}, disp};

		redirect.v      = bb0 || bb1;
		redirect.target = br.pc + disp_ext * addr_t'(INSTR_BYTES);

		// bit 0 kills slot1 and bit 1 kills the other pair
		// a branch in slot1 leaves slot0 alone since slot0 is older
		kill_after = {bb0 || bb1, bb0};
	end

	// the redirect stays up for as long as the branch sits unenqueued in
	// the leading pair, and the pc reloads the same target each cycle

	// a loop of a single pair, where the target lands in the same pair,
	// works the same way since the pair is refetched after the branch leaves

endmodule

/* source/fetch_buffers.sv */
`timescale 1ns/1ps
// fetch buffers holding two instruction pairs with a steering bit that picks the leading pair
module fetch_buffers
	import isa_pkg::*;
	import fetch_pkg::*;
#(
	parameter int ADDR_W = fetch_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              fetch_done,
	input  pair_t             fetch_pair,
	input  logic [ADDR_W-1:0] fetch_pc,
	input  logic              free0,
	input  logic              free1,
	input  logic              flush,
	input  logic [1:0]        kill_after,
	output fb_entry_t         slot0,
	output fb_entry_t         slot1,
	output logic              fetch_want
);

	// pair 0 is AB and pair 1 is CD, indexed as [pair][entry]
	logic [1:0][1:0]   vld_q;
	logic [1:0][1:0]   vld_d;

	// steering bit, it names the pair that holds the oldest entries
	logic              steer_q;
	logic              steer_d;

	logic [ADDR_W-1:0] pc_q [2][2];
	pair_t             instr_q [2];

	logic              lead_v0;
	logic              lead_v1;
	logic              take0;
	logic              take1;
	logic              ld_en;
	logic              ld_sel;

	// ========================================
	// next state
	// ========================================

	always_comb begin
		lead_v0 = vld_q[steer_q][0];
		lead_v1 = vld_q[steer_q][1];

		// entries go in program order and each one needs a free port,
		// free1 only counts behind free0
		take0 = lead_v0 && free0;
		// a killed slot1 is hidden from the queue so it is never taken
		take1 = lead_v1 && !kill_after[0] && (lead_v0 ? (free0 && free1) : free0);

		vld_d   = vld_q;
		steer_d = steer_q;
		ld_en   = 1'b0;
		ld_sel  = !steer_q;

		if (take0) begin
			vld_d[steer_q][0] = 1'b0;
		end
		if (take1 || kill_after[0]) begin
			vld_d[steer_q][1] = 1'b0;
		end
		// bit 1 means a back branch sits in the leading pair, so
		// everything in the other pair is younger and on the wrong path
		if (kill_after[1]) begin
			vld_d[!steer_q] = 2'b00;
		end

		// once the leading pair drains, the other pair becomes the oldest
		if (vld_d[steer_q] == 2'b00 && vld_d[!steer_q] != 2'b00) begin
			steer_d = !steer_q;
		end

		// a fresh pair goes behind whatever is still waiting
		if (fetch_done && !flush) begin
			ld_sel = (vld_d[!steer_d] == 2'b00) ? !steer_d : steer_d;
			ld_en  = (vld_d[ld_sel] == 2'b00);
		end
		if (ld_en) begin
			// nothing older left, so the new pair leads at once and shows
			// up on the slots the cycle after ack
			if (vld_d[steer_d] == 2'b00) begin
				steer_d = ld_sel;
			end
			vld_d[ld_sel] = 2'b11;
		end
	end

	// ========================================
	// registers
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q   <= '0;
			steer_q <= 1'b0;
		end else if (flush) begin
			// a branch miss empties both pairs and starts over at AB
			vld_q   <= '0;
			steer_q <= 1'b0;
		end else begin
			vld_q   <= vld_d;
			steer_q <= steer_d;
		end
	end

	// payload is only meaningful while its valid bit is set
	always_ff @(posedge clk) begin
		if (ld_en) begin
			pc_q[ld_sel][0] <= fetch_pc;
			pc_q[ld_sel][1] <= fetch_pc + ADDR_W'(INSTR_BYTES);
			instr_q[ld_sel] <= fetch_pair;
		end
	end

	// ========================================
	// outputs
	// ========================================

	// the slots are the two entries of the leading pair, empty ones read as nops
	always_comb begin
		slot0.v     = vld_q[steer_q][0];
		slot0.pc    = pc_q[steer_q][0];
		slot0.instr = slot0.v ? instr_q[steer_q][0] : NOP_INSN;
		slot1.v     = vld_q[steer_q][1];
		slot1.pc    = pc_q[steer_q][1];
		slot1.instr = slot1.v ? instr_q[steer_q][1] : NOP_INSN;
	end

	// only whole empty pairs are refilled, and nothing new is fetched while
	// a back branch waits in the leading pair
	assign fetch_want = ((vld_q[0] == 2'b00) || (vld_q[1] == 2'b00)) && (kill_after == 2'b00);

endmodule

/* source/fetch_bus.sv */
`timescale 1ns/1ps
// instruction bus master that reads one pair per bus cycle and drops stale replies
module fetch_bus
	import fetch_pkg::*;
#(
	parameter int ADDR_W = fetch_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [ADDR_W-1:0] pc,
	input  logic              fetch_want,
	input  logic              redirect_seen,
	output wb_req_t           wb_req,
	input  wb_rsp_t           wb_rsp,
	output logic              fetch_done,
	output pair_t             fetch_pair,
	output logic [ADDR_W-1:0] fetch_pc
);

	typedef enum logic {
		BUS_IDLE,
		BUS_OPEN
	} bus_state_e;

	bus_state_e        state_q;
	logic              stale_q;
	logic [ADDR_W-1:0] adr_q;

	// ========================================
	// cycle control
	// ========================================

	// a new cycle opens the edge after fetch_want is seen while idle
	// and closes on the edge that carries ack
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= BUS_IDLE;
			stale_q <= 1'b0;
		end else begin
			case (state_q)
				BUS_IDLE: begin
					// hold off while the pc is being reloaded, so the
					// latched address is never the one being replaced
					if (fetch_want && !redirect_seen) begin
						state_q <= BUS_OPEN;
						stale_q <= 1'b0;
					end
				end
				BUS_OPEN: begin
					if (wb_rsp.ack) begin
						state_q <= BUS_IDLE;
					end else if (redirect_seen) begin
						// the reply still has to be waited for but its
						// data belongs to the wrong path
						stale_q <= 1'b1;
					end
				end
				default: state_q <= BUS_IDLE;
			endcase
		end
	end

	// the request address is captured once and held for the whole cycle
	always_ff @(posedge clk) begin
		if (state_q == BUS_IDLE && fetch_want) begin
			adr_q <= pc;
		end
	end

	// cyc and stb rise and fall together
	assign wb_req.cyc = (state_q == BUS_OPEN);
	assign wb_req.stb = (state_q == BUS_OPEN);
	assign wb_req.adr = adr_q;
	assign wb_req.we  = 1'b0;

	// ========================================
	// reply forwarding
	// ========================================

	// a redirect in the ack cycle itself also kills the reply
	assign fetch_done = (state_q == BUS_OPEN) && wb_rsp.ack && !stale_q && !redirect_seen;
	assign fetch_pair = wb_rsp.dat;
	assign fetch_pc   = adr_q;

endmodule

/* source/fetch_pc.sv */
`timescale 1ns/1ps
// fetch program counter that takes redirects or steps one instruction pair per fetch
module fetch_pc
	import fetch_pkg::*;
#(
	parameter int ADDR_W = fetch_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              fetch_done,
	input  redirect_t         redirect,
	output logic [ADDR_W-1:0] pc
);

	// the pc always names the next pair to be requested
	logic [ADDR_W-1:0] pc_next;

	// ========================================
	// next address
	// ========================================

	always_comb begin
		pc_next = pc;
		// a redirect wins over the step because anything fetched
		// around it is thrown away anyway
		if (redirect.v) begin
			pc_next = redirect.target;
		end else if (fetch_done) begin
			// one pair has landed in the buffers so move past it
			pc_next = pc + ADDR_W'(PAIR_BYTES);
		end
	end

	// ========================================
	// register
	// ========================================

	// execution starts at address zero
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// note that a redirect held over several cycles reloads the same
	// target each time, which keeps the pc parked on it until the
	// branch that caused it has been taken by the queue

	// the target need not be pair aligned, the bus simply reads the
	// two words starting at whatever address it is handed

	// fetch_done only arrives for replies that are still current, so a
	// stale reply never advances past a redirect target

endmodule

/* source/fetch_pkg.sv */
// fetch transport package with buffer entries, redirects and the instruction bus types
package fetch_pkg;

	import isa_pkg::*;

	// ========================================
	// address space
	// ========================================

	// default width, the top level takes it as its own parameter
	localparam int ADDR_W = 32;

	// each bus read returns two instructions
	localparam int PAIR_BYTES = 2 * INSTR_BYTES;

	typedef logic [ADDR_W-1:0] addr_t;

	// index 0 holds the instruction at the lower address
	typedef instr_t [1:0] pair_t;

	// one fetch buffer entry, also the slot type seen by the queue
	typedef struct packed {
		logic   v;
		addr_t  pc;
		instr_t instr;
	} fb_entry_t;

	// a request to restart fetch somewhere else
	typedef struct packed {
		logic  v;
		addr_t target;
	} redirect_t;

	// ========================================
	// wishbone classic
	// ========================================

	// master side, the front end never writes so we is tied low
	typedef struct packed {
		logic  cyc;
		logic  stb;
		addr_t adr;
		logic  we;
	} wb_req_t;

	// slave side, ack is a single cycle strobe that comes with the data
	typedef struct packed {
		logic  ack;
		pair_t dat;
	} wb_rsp_t;

endpackage

/* source/isa_pkg.sv */
// instruction set package with the encodings and branch decode used by the fetch path
package isa_pkg;

	// ========================================
	// field widths
	// ========================================

	localparam int INSTR_W  = 32;
	localparam int OPCODE_W = 7;

	// the branch displacement sits in the top half of the word
	localparam int DISP_W   = 16;
	localparam int DISP_LSB = INSTR_W - DISP_W;

	// one instruction per word, so a pair covers two words
	localparam int INSTR_BYTES = INSTR_W / 8;

	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [OPCODE_W-1:0] opcode_t;

	// displacement counts instructions, not bytes
	typedef logic signed [DISP_W-1:0] disp_t;

	// ========================================
	// opcodes
	// ========================================

	localparam opcode_t OP_NOP = 7'h00;
	localparam opcode_t OP_BRA = 7'h2b;

	// the all-zero word decodes as a nop
	localparam instr_t NOP_INSN = {{(INSTR_W-OPCODE_W){1'b0}}, OP_NOP};

	function automatic opcode_t opcode_of(input instr_t insn);
		return insn[OPCODE_W-1:0];
	endfunction

	function automatic disp_t branch_disp(input instr_t insn);
		return disp_t'(insn[INSTR_W-1:DISP_LSB]);
	endfunction

	// a branch goes backwards when its displacement is negative
	function automatic logic is_back_branch(input instr_t insn);
		disp_t disp;
		disp = branch_disp(insn);
		return (opcode_of(insn) == OP_BRA) && disp[DISP_W-1];
	endfunction

endpackage
